// File: include/requant_defs.svh
//****************************************
// Requantization parameters
// Lane count, datapath widths and the
// fixed-point format of the lane scales
//****************************************

`ifndef REQUANT_DEFS_SVH
`define REQUANT_DEFS_SVH

// Lanes per vector, power of two only
`define NUM_LANES 8

// Signed partial sum and accumulator width
`define IN_WIDTH 20

// Signed int8 result
`define OUT_WIDTH 8

// Signed per-lane scale, Q0.15
`define SCALE_BITS 16
`define SCALE_FRAC 15

// Unsigned extra right shift per lane
`define SHIFT_BITS 4

`endif

// File: design/nn_ctrl_pkg.sv
//****************************************
// Control encodings
// Activation opcode and accumulator FSM
//****************************************

`default_nettype none

package nn_ctrl_pkg;

    // Activation selected per vector
    typedef enum logic {
        ACT_NONE = 1'b0,
        ACT_RELU = 1'b1
    } act_op_e;

    // Accumulator FSM, RUN between first and last beat
    typedef enum logic {
        ACC_IDLE = 1'b0,
        ACC_RUN  = 1'b1
    } acc_state_e;

endpackage

`default_nettype wire

// File: design/nn_types_pkg.sv
//****************************************
// Datapath types
// Lane vectors and the strobed records
// passed between pipeline stages
//****************************************

`default_nettype none

`include "requant_defs.svh"

package nn_types_pkg;

    typedef logic signed [`IN_WIDTH-1:0]  acc_lane_t;
    typedef logic signed [`OUT_WIDTH-1:0] q_lane_t;

    typedef acc_lane_t [`NUM_LANES-1:0] acc_vec_t;
    typedef q_lane_t   [`NUM_LANES-1:0] q_vec_t;

    // One partial-sum beat from the MAC array
    typedef struct packed {
        logic     valid;
        logic     first;
        logic     last;
        acc_vec_t data;
    } psum_beat_t;

    // Finished accumulator vector
    typedef struct packed {
        logic                 valid;
        nn_ctrl_pkg::act_op_e op;
        acc_vec_t             data;
    } acc_out_t;

    // Requantized int8 vector
    typedef struct packed {
        logic                 valid;
        nn_ctrl_pkg::act_op_e op;
        q_vec_t               data;
    } q_out_t;

endpackage

`default_nettype wire

// File: design/accumulator_bank.sv
//****************************************
// Accumulator bank
// Sums partial-sum beats per lane and
// emits one vector per last beat
//****************************************

`timescale 1ns/1ps
`default_nettype none

`include "requant_defs.svh"

module accumulator_bank (
    input  wire                      clk,
    input  wire                      nrst,
    input  wire nn_types_pkg::psum_beat_t beat_i,
    input  wire nn_ctrl_pkg::act_op_e     op_i,
    output nn_types_pkg::acc_out_t        acc_o
);

    nn_ctrl_pkg::acc_state_e state_q;
    nn_ctrl_pkg::act_op_e    op_q;
    logic                    valid_q;
    nn_types_pkg::acc_vec_t  acc_q;
    logic                    beat_first;
    logic                    beat_last;

    assign beat_first = beat_i.valid && beat_i.first;
    assign beat_last  = beat_i.valid && beat_i.last;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= nn_ctrl_pkg::ACC_IDLE;
            op_q    <= nn_ctrl_pkg::ACT_NONE;
            valid_q <= 1'b0;
        end else begin
            valid_q <= beat_last;
            // Opcode belongs to the vector opened by first
            if (beat_first) begin
                op_q <= op_i;
            end
            if (beat_last) begin
                state_q <= nn_ctrl_pkg::ACC_IDLE;
            end else if (beat_first) begin
                state_q <= nn_ctrl_pkg::ACC_RUN;
            end
        end
    end

    // Lane sums, wrapping at IN_WIDTH
    always_ff @(posedge clk) begin
        if (beat_first) begin
            acc_q <= beat_i.data;
        end else if (beat_i.valid && state_q == nn_ctrl_pkg::ACC_RUN) begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                acc_q[i] <= acc_q[i] + beat_i.data[i];
            end
        end
    end

    // Sum stays stable during the valid cycle, even with a new first
    always_comb begin
        acc_o.valid = valid_q;
        acc_o.op    = op_q;
        acc_o.data  = acc_q;
    end

    a_open_with_first: assert property (@(posedge clk) disable iff (!nrst)
        (beat_i.valid && state_q == nn_ctrl_pkg::ACC_IDLE) |-> beat_i.first)
        else $error("beat without first while idle");

    a_no_first_in_run: assert property (@(posedge clk) disable iff (!nrst)
        (beat_i.valid && state_q == nn_ctrl_pkg::ACC_RUN) |-> !beat_i.first)
        else $error("first beat while a vector is open");

endmodule

`default_nettype wire

// File: design/output_scaler.sv
//****************************************
// Output scaler, one lane
// Scale multiply, then rounding shift
// and int8 saturation
//****************************************

`timescale 1ns/1ps
`default_nettype none

`include "requant_defs.svh"

module output_scaler (
    input  wire                          clk,
    input  wire                          nrst,
    input  wire signed [`IN_WIDTH-1:0]   acc_i,
    input  wire signed [`SCALE_BITS-1:0] scale_i,
    input  wire        [`SHIFT_BITS-1:0] shift_i,
    output logic signed [`OUT_WIDTH-1:0] y_o
);

    localparam int PROD_W = `IN_WIDTH + `SCALE_BITS;
    // One guard bit for the rounding add
    localparam int RND_W  = PROD_W + 1;
    localparam int TSH_W  = $clog2(`SCALE_FRAC + (2 ** `SHIFT_BITS));
    localparam logic signed [`OUT_WIDTH-1:0] OUT_MAX = (2 ** (`OUT_WIDTH - 1)) - 1;
    localparam logic signed [`OUT_WIDTH-1:0] OUT_MIN = -(2 ** (`OUT_WIDTH - 1));

    logic signed [PROD_W-1:0]     prod_q;
    logic        [`SHIFT_BITS-1:0] shift_q;
    logic        [TSH_W-1:0]       total_sh;
    logic signed [RND_W-1:0]       rnd_bias;
    logic signed [RND_W-1:0]       rounded;
    logic signed [RND_W-1:0]       shifted;

    // Stage one, product with its shift
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            prod_q  <= '0;
            shift_q <= '0;
        end else begin
            prod_q  <= acc_i * scale_i;
            shift_q <= shift_i;
        end
    end

    // Round half up, then arithmetic shift
    always_comb begin
        total_sh = TSH_W'(`SCALE_FRAC) + TSH_W'(shift_q);
        rnd_bias = RND_W'(1) << (total_sh - 1'b1);
        rounded  = prod_q + rnd_bias;
        shifted  = rounded >>> total_sh;
    end

    // Stage two, clamp to int8
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            y_o <= '0;
        end else if (shifted > OUT_MAX) begin
            y_o <= OUT_MAX;
        end else if (shifted < OUT_MIN) begin
            y_o <= OUT_MIN;
        end else begin
            y_o <= shifted[`OUT_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// File: design/output_scaler_set.sv
//****************************************
// Output scaler set
// Per-lane scale and shift register files
// loaded as serial streams, one scaler
// per lane
//****************************************

`timescale 1ns/1ps
`default_nettype none

`include "requant_defs.svh"

module output_scaler_set (
    input  wire                          clk,
    input  wire                          nrst,
    input  wire nn_types_pkg::acc_out_t  acc_i,
    output nn_types_pkg::q_out_t         q_o,
    input  wire                          scale_w_en_i,
    input  wire signed [`SCALE_BITS-1:0] scale_w_data_i,
    input  wire                          shift_w_en_i,
    input  wire        [`SHIFT_BITS-1:0] shift_w_data_i
);

    localparam int PTR_W = $clog2(`NUM_LANES);

    logic signed [`SCALE_BITS-1:0] scale_rf [`NUM_LANES];
    logic        [`SHIFT_BITS-1:0] shift_rf [`NUM_LANES];
    logic        [PTR_W-1:0]       scale_ptr;
    logic        [PTR_W-1:0]       shift_ptr;
    logic        [1:0]             valid_sr;
    nn_ctrl_pkg::act_op_e          op_d1;
    nn_ctrl_pkg::act_op_e          op_d2;
    nn_types_pkg::q_vec_t          lane_y;

    // Scale stream, pointer wraps by overflow
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                scale_rf[i] <= '0;
            end
            scale_ptr <= '0;
        end else if (scale_w_en_i) begin
            scale_rf[scale_ptr] <= scale_w_data_i;
            scale_ptr           <= scale_ptr + 1'b1;
        end
    end

    // Shift stream keeps its own pointer
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                shift_rf[i] <= '0;
            end
            shift_ptr <= '0;
        end else if (shift_w_en_i) begin
            shift_rf[shift_ptr] <= shift_w_data_i;
            shift_ptr           <= shift_ptr + 1'b1;
        end
    end

    // Valid and opcode follow the two lane stages
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid_sr <= 2'b00;
            op_d1    <= nn_ctrl_pkg::ACT_NONE;
            op_d2    <= nn_ctrl_pkg::ACT_NONE;
        end else begin
            valid_sr <= {valid_sr[0], acc_i.valid};
            op_d1    <= acc_i.op;
            op_d2    <= op_d1;
        end
    end

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        output_scaler u_scaler (
            .clk     (clk),
            .nrst    (nrst),
            .acc_i   (acc_i.data[i]),
            .scale_i (scale_rf[i]),
            .shift_i (shift_rf[i]),
            .y_o     (lane_y[i])
        );
    end

    always_comb begin
        q_o.valid = valid_sr[1];
        q_o.op    = op_d2;
        q_o.data  = lane_y;
    end

    // Overflow wrap lands on lane 0 only for a power-of-two lane count
    a_lanes_pow2: assert property (@(posedge clk)
        (`NUM_LANES & (`NUM_LANES - 1)) == 0)
        else $error("NUM_LANES must be a power of two");

endmodule

`default_nettype wire

// File: design/activation_stage.sv
//****************************************
// Activation stage
// Registers the int8 vector, optional ReLU
//****************************************

`timescale 1ns/1ps
`default_nettype none

`include "requant_defs.svh"

module activation_stage (
    input  wire                        clk,
    input  wire                        nrst,
    input  wire nn_types_pkg::q_out_t  q_i,
    output nn_types_pkg::q_out_t       q_o
);

    logic                 valid_q;
    nn_ctrl_pkg::act_op_e op_q;
    nn_types_pkg::q_vec_t data_q;
    logic                 any_neg;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid_q <= 1'b0;
            op_q    <= nn_ctrl_pkg::ACT_NONE;
        end else begin
            valid_q <= q_i.valid;
            op_q    <= q_i.op;
        end
    end

    // ReLU zeroes lanes with the sign bit set
    always_ff @(posedge clk) begin
        if (q_i.valid) begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                if (q_i.op == nn_ctrl_pkg::ACT_RELU && q_i.data[i][`OUT_WIDTH-1]) begin
                    data_q[i] <= '0;
                end else begin
                    data_q[i] <= q_i.data[i];
                end
            end
        end
    end

    always_comb begin
        q_o.valid = valid_q;
        q_o.op    = op_q;
        q_o.data  = data_q;
        any_neg   = 1'b0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            any_neg = any_neg | data_q[i][`OUT_WIDTH-1];
        end
    end

    a_relu_nonneg: assert property (@(posedge clk) disable iff (!nrst)
        (q_o.valid && q_o.op == nn_ctrl_pkg::ACT_RELU) |-> !any_neg)
        else $error("negative lane on a ReLU output");

endmodule

`default_nettype wire

// File: design/requant_top.sv
//****************************************
// Requantization output stage
// Accumulate, scale to int8, activate
//****************************************

`timescale 1ns/1ps
`default_nettype none

`include "requant_defs.svh"

module requant_top (
    input  wire                            clk,
    input  wire                            nrst,
    input  wire nn_types_pkg::psum_beat_t  beat_i,
    input  wire nn_ctrl_pkg::act_op_e      op_i,
    input  wire                            scale_w_en_i,
    input  wire signed [`SCALE_BITS-1:0]   scale_w_data_i,
    input  wire                            shift_w_en_i,
    input  wire        [`SHIFT_BITS-1:0]   shift_w_data_i,
    output nn_types_pkg::q_out_t           q_o
);

    // Opcode rides with each vector through the stage records
    nn_types_pkg::acc_out_t acc_s;
    nn_types_pkg::q_out_t   scaled_s;

    accumulator_bank u_acc (
        .clk    (clk),
        .nrst   (nrst),
        .beat_i (beat_i),
        .op_i   (op_i),
        .acc_o  (acc_s)
    );

    output_scaler_set u_scale (
        .clk            (clk),
        .nrst           (nrst),
        .acc_i          (acc_s),
        .q_o            (scaled_s),
        .scale_w_en_i   (scale_w_en_i),
        .scale_w_data_i (scale_w_data_i),
        .shift_w_en_i   (shift_w_en_i),
        .shift_w_data_i (shift_w_data_i)
    );

    activation_stage u_act (
        .clk  (clk),
        .nrst (nrst),
        .q_i  (scaled_s),
        .q_o  (q_o)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
//****************************************
// Testbench clock and reset
// 4 ns clock, reset low for 4 cycles
//****************************************

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release on a rising edge after four cycles
    initial begin
        nrst = 1'b0;
        repeat (4) @(posedge clk);
        nrst <= 1'b1;
    end

endmodule

`default_nettype wire

// File: test/requant_checker.sv
//****************************************
// Requantization checker
// Models accumulation, scale streams and
// the int8 rule, compares each output
//****************************************

`timescale 1ns/1ps
`default_nettype none

`include "requant_defs.svh"

module requant_checker (
    input  wire                           clk,
    input  wire                           nrst,
    input  wire nn_types_pkg::psum_beat_t beat_i,
    input  wire nn_ctrl_pkg::act_op_e     op_i,
    input  wire                           scale_w_en_i,
    input  wire signed [`SCALE_BITS-1:0]  scale_w_data_i,
    input  wire                           shift_w_en_i,
    input  wire        [`SHIFT_BITS-1:0]  shift_w_data_i,
    input  wire nn_types_pkg::q_out_t     q_i,
    output int                            pending_o,
    output int                            err_count_o,
    output int                            tests_done_o,
    output int                            tests_failed_o
);

    // Output valid follows the last beat by this many cycles
    localparam int LATENCY = 4;

    nn_types_pkg::acc_vec_t        sum_m;
    logic signed [`SCALE_BITS-1:0] scale_m [`NUM_LANES];
    logic        [`SHIFT_BITS-1:0] shift_m [`NUM_LANES];
    int                            scale_wp;
    int                            shift_wp;
    logic                          relu_m;
    string                         name_m;
    int                            cycle;
    string                         names_q [$];
    string                         exp_name_q [$];
    nn_types_pkg::q_vec_t          exp_data_q [$];
    logic                          exp_relu_q [$];
    int                            exp_due_q [$];

    task automatic note_test(string name);
        names_q.push_back(name);
    endtask

    // Scale, round half up, clamp, then optional ReLU
    function automatic logic signed [`OUT_WIDTH-1:0] requant_lane(longint acc, longint scale,
                                                                 int sh, logic relu);
        longint hi;
        longint lo;
        longint res;
        int     total;
        hi    = (longint'(1) <<< (`OUT_WIDTH - 1)) - 1;
        lo    = -hi - 1;
        total = `SCALE_FRAC + sh;
        res   = (acc * scale + (longint'(1) <<< (total - 1))) >>> total;
        if (res > hi) begin
            res = hi;
        end else if (res < lo) begin
            res = lo;
        end
        if (relu && res < 0) begin
            res = 0;
        end
        return `OUT_WIDTH'(res);
    endfunction

    task automatic finish_test(string name, int errs);
        err_count_o  += errs;
        tests_done_o += 1;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed_o += 1;
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    task automatic check_output();
        nn_types_pkg::q_vec_t exp;
        logic                 relu;
        int                   due;
        string                name;
        int                   errs;
        exp  = exp_data_q.pop_front();
        relu = exp_relu_q.pop_front();
        due  = exp_due_q.pop_front();
        name = exp_name_q.pop_front();
        errs = 0;
        if (due != cycle) begin
            $display("test %s: output came at cycle %0d, not at cycle %0d", name, cycle, due);
            errs++;
        end
        if ((q_i.op == nn_ctrl_pkg::ACT_RELU) !== relu) begin
            $display("mismatch at %0t: q_o.op got %0d expected %0d", $time, q_i.op, relu);
            errs++;
        end
        for (int i = 0; i < `NUM_LANES; i++) begin
            if (q_i.data[i] !== exp[i]) begin
                $display("mismatch at %0t: q_o.data[%0d] got %0d expected %0d",
                         $time, i, $signed(q_i.data[i]), $signed(exp[i]));
                errs++;
            end
        end
        finish_test(name, errs);
    endtask

    task automatic report_missing();
        string name;
        int    due;
        name = exp_name_q.pop_front();
        due  = exp_due_q.pop_front();
        void'(exp_data_q.pop_front());
        void'(exp_relu_q.pop_front());
        $display("test %s: no output valid by cycle %0d", name, due);
        finish_test(name, 1);
    endtask

    task automatic record_beat();
        nn_types_pkg::q_vec_t exp;
        if (beat_i.first) begin
            sum_m  = beat_i.data;
            relu_m = (op_i == nn_ctrl_pkg::ACT_RELU);
            if (names_q.size() > 0) begin
                name_m = names_q.pop_front();
            end else begin
                name_m = "unnamed";
            end
        end else begin
            // Sums wrap at the accumulator width
            for (int i = 0; i < `NUM_LANES; i++) begin
                sum_m[i] = sum_m[i] + beat_i.data[i];
            end
        end
        if (beat_i.last) begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                exp[i] = requant_lane($signed(sum_m[i]), scale_m[i], int'(shift_m[i]), relu_m);
            end
            exp_data_q.push_back(exp);
            exp_relu_q.push_back(relu_m);
            exp_name_q.push_back(name_m);
            exp_due_q.push_back(cycle + LATENCY);
        end
    endtask

    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                scale_m[i] = '0;
                shift_m[i] = '0;
            end
            scale_wp = 0;
            shift_wp = 0;
            cycle    = 0;
        end else begin
            cycle++;
            if (q_i.valid) begin
                if (exp_due_q.size() == 0) begin
                    $display("output valid at %0t with no vector pending", $time);
                    err_count_o += 1;
                end else begin
                    check_output();
                end
            end else if (exp_due_q.size() > 0 && exp_due_q[0] < cycle) begin
                report_missing();
            end
            // Each stream keeps its own wrapping pointer
            if (scale_w_en_i) begin
                scale_m[scale_wp] = scale_w_data_i;
                scale_wp          = (scale_wp + 1) % `NUM_LANES;
            end
            if (shift_w_en_i) begin
                shift_m[shift_wp] = shift_w_data_i;
                shift_wp          = (shift_wp + 1) % `NUM_LANES;
            end
            if (beat_i.valid) begin
                record_beat();
            end
        end
        pending_o = exp_due_q.size();
    end

endmodule

`default_nettype wire

// File: test/tb_requant_top.sv
//****************************************
// Requantization testbench
// Table-driven vectors with xorshift data
// through the three-stage pipeline
//****************************************

`timescale 1ns/1ps
`default_nettype none

`include "requant_defs.svh"

module tb_requant_top;

    localparam logic [31:0] SEED = 32'hc7fbea2d;
    localparam int R_SMALL = 0;
    localparam int R_POS   = 1;
    localparam int R_NEG   = 2;
    localparam int R_HALF  = 3;

    // Sixteen stream entries with entry k at slice k
    localparam logic [16*`SCALE_BITS-1:0] SCALES =
        256'h4000_9C40_1000_4000_E000_6000_4000_8000_7530_4000_B1E0_3039_2000_7FFF_C000_4000;
    localparam logic [16*`SHIFT_BITS-1:0] SHIFTS = 64'h1730_5201_4130_2100;

    wire                           clk;
    wire                           nrst;
    nn_types_pkg::psum_beat_t      beat_r;
    nn_ctrl_pkg::act_op_e          op_r;
    logic                          scale_en_r;
    logic signed [`SCALE_BITS-1:0] scale_data_r;
    logic                          shift_en_r;
    logic        [`SHIFT_BITS-1:0] shift_data_r;
    nn_types_pkg::q_out_t          q_s;
    wire         [31:0]            pending;
    wire         [31:0]            err_count;
    wire         [31:0]            tests_done;
    wire         [31:0]            tests_failed;

    string                t_name [$];
    int                   t_beats [$];
    nn_ctrl_pkg::act_op_e t_op [$];
    int                   t_range [$];
    bit                   t_b2b [$];
    int                   t_nscale [$];
    int                   t_nshift [$];

    logic [31:0] rng;
    int          scale_k;
    int          shift_k;
    int          cycles = 0;
    int          limit;

    tb_clock_gen u_clk (
        .clk  (clk),
        .nrst (nrst)
    );

    requant_top dut_i (
        .clk            (clk),
        .nrst           (nrst),
        .beat_i         (beat_r),
        .op_i           (op_r),
        .scale_w_en_i   (scale_en_r),
        .scale_w_data_i (scale_data_r),
        .shift_w_en_i   (shift_en_r),
        .shift_w_data_i (shift_data_r),
        .q_o            (q_s)
    );

    requant_checker u_checker (
        .clk            (clk),
        .nrst           (nrst),
        .beat_i         (beat_r),
        .op_i           (op_r),
        .scale_w_en_i   (scale_en_r),
        .scale_w_data_i (scale_data_r),
        .shift_w_en_i   (shift_en_r),
        .shift_w_data_i (shift_data_r),
        .q_i            (q_s),
        .pending_o      (pending),
        .err_count_o    (err_count),
        .tests_done_o   (tests_done),
        .tests_failed_o (tests_failed)
    );

    task automatic add_row(string name, int beats, nn_ctrl_pkg::act_op_e op, int range,
                           bit b2b, int n_scale, int n_shift);
        t_name.push_back(name);
        t_beats.push_back(beats);
        t_op.push_back(op);
        t_range.push_back(range);
        t_b2b.push_back(b2b);
        t_nscale.push_back(n_scale);
        t_nshift.push_back(n_shift);
    endtask

    function automatic logic [31:0] next_rand(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Four beats of the large ranges still fit in IN_WIDTH
    function automatic logic signed [`IN_WIDTH-1:0] lane_value(int range, logic [31:0] r);
        int mag;
        mag = int'(r & 32'hFFFF);
        case (range)
            R_POS:   return `IN_WIDTH'(65536 + mag);
            R_NEG:   return `IN_WIDTH'(-65536 - mag);
            // Odd values land exactly halfway on the 0.5 scale lanes
            R_HALF:  return `IN_WIDTH'(2 * int'(r & 32'h3F) - 63);
            default: return `IN_WIDTH'(int'(r & 32'h7F) - 64);
        endcase
    endfunction

    task automatic write_config(int n_scale, int n_shift);
        int n;
        n = (n_scale > n_shift) ? n_scale : n_shift;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            scale_en_r   <= (i < n_scale);
            scale_data_r <= SCALES[(scale_k % 16) * `SCALE_BITS +: `SCALE_BITS];
            shift_en_r   <= (i < n_shift);
            shift_data_r <= SHIFTS[(shift_k % 16) * `SHIFT_BITS +: `SHIFT_BITS];
            if (i < n_scale) begin
                scale_k++;
            end
            if (i < n_shift) begin
                shift_k++;
            end
        end
        @(posedge clk);
        scale_en_r <= 1'b0;
        shift_en_r <= 1'b0;
    endtask

    task automatic drive_vector(int t);
        nn_types_pkg::psum_beat_t b;
        nn_ctrl_pkg::act_op_e     other_op;
        if (t_op[t] == nn_ctrl_pkg::ACT_RELU) begin
            other_op = nn_ctrl_pkg::ACT_NONE;
        end else begin
            other_op = nn_ctrl_pkg::ACT_RELU;
        end
        for (int k = 0; k < t_beats[t]; k++) begin
            b.valid = 1'b1;
            b.first = (k == 0);
            b.last  = (k == t_beats[t] - 1);
            for (int i = 0; i < `NUM_LANES; i++) begin
                rng       = next_rand(rng);
                b.data[i] = lane_value(t_range[t], rng);
            end
            @(posedge clk);
            beat_r <= b;
            // Only the first beat's opcode belongs to the vector
            if (k == 0) begin
                op_r <= t_op[t];
            end else begin
                op_r <= other_op;
            end
        end
    endtask

    // Idle the beat bus until every issued vector has come out
    task automatic wait_drain();
        @(posedge clk);
        beat_r <= '0;
        do begin
            @(negedge clk);
        end while (pending != 0);
    endtask

    initial begin
        beat_r       = '0;
        op_r         = nn_ctrl_pkg::ACT_NONE;
        scale_en_r   = 1'b0;
        scale_data_r = '0;
        shift_en_r   = 1'b0;
        shift_data_r = '0;
        rng          = SEED;
        scale_k      = 0;
        shift_k      = 0;

        add_row("single_none",    1, nn_ctrl_pkg::ACT_NONE, R_SMALL, 0, 8, 8);
        add_row("single_repeat",  1, nn_ctrl_pkg::ACT_NONE, R_SMALL, 0, 0, 0);
        add_row("halfway",        1, nn_ctrl_pkg::ACT_NONE, R_HALF,  0, 0, 0);
        add_row("two_beat",       2, nn_ctrl_pkg::ACT_NONE, R_SMALL, 0, 0, 0);
        add_row("four_beat",      4, nn_ctrl_pkg::ACT_NONE, R_SMALL, 0, 0, 0);
        add_row("sat_pos",        3, nn_ctrl_pkg::ACT_NONE, R_POS,   0, 0, 0);
        add_row("sat_neg",        4, nn_ctrl_pkg::ACT_NONE, R_NEG,   0, 0, 0);
        add_row("relu_small",     2, nn_ctrl_pkg::ACT_RELU, R_SMALL, 0, 0, 0);
        add_row("relu_sat_neg",   1, nn_ctrl_pkg::ACT_RELU, R_NEG,   0, 0, 0);
        add_row("b2b_lead",       2, nn_ctrl_pkg::ACT_NONE, R_SMALL, 0, 0, 0);
        add_row("b2b_relu",       1, nn_ctrl_pkg::ACT_RELU, R_SMALL, 1, 0, 0);
        add_row("b2b_pos",        3, nn_ctrl_pkg::ACT_NONE, R_POS,   1, 0, 0);
        add_row("b2b_tail",       1, nn_ctrl_pkg::ACT_RELU, R_NEG,   1, 0, 0);
        add_row("rewrite_uneven", 2, nn_ctrl_pkg::ACT_NONE, R_SMALL, 0, 8, 3);
        add_row("shift_catchup",  1, nn_ctrl_pkg::ACT_NONE, R_HALF,  0, 0, 5);
        add_row("after_wrap",     4, nn_ctrl_pkg::ACT_RELU, R_SMALL, 0, 0, 0);

        // Config write cycles are counted along with the beats
        limit = 0;
        for (int t = 0; t < t_name.size(); t++) begin
            limit += t_beats[t] + t_nscale[t] + t_nshift[t] + 20;
        end

        wait (nrst === 1'b1);
        for (int t = 0; t < t_name.size(); t++) begin
            if (!t_b2b[t]) begin
                wait_drain();
            end
            if (t_nscale[t] > 0 || t_nshift[t] > 0) begin
                write_config(t_nscale[t], t_nshift[t]);
            end
            u_checker.note_test(t_name[t]);
            drive_vector(t);
        end
        wait_drain();

        $display("tests %0d, failed %0d, errors %0d", tests_done, tests_failed, err_count);
        if (err_count == 0 && tests_done == t_name.size()) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run still going after %0d cycles", limit);
            $display("TB FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
design/nn_ctrl_pkg.sv
design/nn_types_pkg.sv
design/accumulator_bank.sv
design/output_scaler.sv
design/output_scaler_set.sv
design/activation_stage.sv
design/requant_top.sv
test/tb_clock_gen.sv
test/requant_checker.sv
test/tb_requant_top.sv

// File: Bender.yml
package:
  name: requant

export_include_dirs:
  - include

sources:
  - files:
      - design/nn_ctrl_pkg.sv
      - design/nn_types_pkg.sv
      - design/accumulator_bank.sv
      - design/output_scaler.sv
      - design/output_scaler_set.sv
      - design/activation_stage.sv
      - design/requant_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/requant_checker.sv
      - test/tb_requant_top.sv
